/* flist.f */
hdl/dispatch_pkg.sv
hdl/control_unit.sv
hdl/reg_status_table.sv
hdl/fu_status.sv
hdl/dispatch.sv
hdl/dispatch_top.sv
verif/dispatch_tb.sv

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  dispatch_pkg::instr_u   instr,
    output dispatch_pkg::fu_type_e fu_type,
    output logic [2:0]             fu_idx,
    output logic                   s_reg_write,
    output logic                   m_reg_write,
    output logic [31:0]            imm,
    output dispatch_pkg::alu_op_e  alu_op,
    output logic                   is_branch
);

    logic [31:0]           word;
    logic [31:0]           imm_i;
    logic [31:0]           imm_s;
    logic [31:0]           imm_b;
    logic                  alt_fn;
    dispatch_pkg::alu_op_e arith_op;

    assign word = instr;

    // sign-extended immediates in the scalar formats
    assign imm_i = {{20{word[31]}}, word[31:20]};
    assign imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
    assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};

    // funct7 bit 5 selects sub and sra; immediates only use it for srai
    assign alt_fn = instr.s.funct7[5]
                    && (instr.s.opcode == dispatch_pkg::OP_ALU_R || instr.s.funct3 == 3'd5);

    always_comb begin
        case (instr.s.funct3)
            3'd0:    arith_op = alt_fn ? dispatch_pkg::ALU_SUB : dispatch_pkg::ALU_ADD;
            3'd1:    arith_op = dispatch_pkg::ALU_SLL;
            3'd2:    arith_op = dispatch_pkg::ALU_SLT;
            3'd3:    arith_op = dispatch_pkg::ALU_SLTU;
            3'd4:    arith_op = dispatch_pkg::ALU_XOR;
            3'd5:    arith_op = alt_fn ? dispatch_pkg::ALU_SRA : dispatch_pkg::ALU_SRL;
            3'd6:    arith_op = dispatch_pkg::ALU_OR;
            default: arith_op = dispatch_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        fu_type     = dispatch_pkg::FU_NONE;
        fu_idx      = dispatch_pkg::FU_ALU;
        s_reg_write = 1'b0;
        m_reg_write = 1'b0;
        imm         = '0;
        alu_op      = dispatch_pkg::ALU_ADD;
        is_branch   = 1'b0;

        case (instr.s.opcode)
            dispatch_pkg::OP_ALU_R: begin
                fu_type     = dispatch_pkg::FU_S;
                s_reg_write = 1'b1;
                alu_op      = arith_op;
            end
            dispatch_pkg::OP_ALU_I: begin
                fu_type     = dispatch_pkg::FU_S;
                s_reg_write = 1'b1;
                imm         = imm_i;
                alu_op      = arith_op;
            end
            dispatch_pkg::OP_LOAD: begin
                fu_type     = dispatch_pkg::FU_S;
                fu_idx      = dispatch_pkg::FU_LDST;
                s_reg_write = 1'b1;
                imm         = imm_i;
            end
            dispatch_pkg::OP_STORE: begin
                fu_type = dispatch_pkg::FU_S;
                fu_idx  = dispatch_pkg::FU_LDST;
                imm     = imm_s;
            end
            dispatch_pkg::OP_BRANCH: begin
                fu_type   = dispatch_pkg::FU_S;
                fu_idx    = dispatch_pkg::FU_BRANCH;
                imm       = imm_b;
                alu_op    = dispatch_pkg::ALU_SUB;
                is_branch = 1'b1;
            end
            dispatch_pkg::OP_M_LOAD: begin
                fu_type     = dispatch_pkg::FU_M;
                fu_idx      = dispatch_pkg::FU_MLDST;
                m_reg_write = 1'b1;
                imm         = imm_i;
            end
            dispatch_pkg::OP_M_STORE: begin
                fu_type = dispatch_pkg::FU_M;
                fu_idx  = dispatch_pkg::FU_MLDST;
                imm     = imm_s;
            end
            dispatch_pkg::OP_GEMM: begin
                fu_type     = dispatch_pkg::FU_G;
                fu_idx      = dispatch_pkg::FU_GEMM;
                m_reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/dispatch.sv */
`timescale 1ns/1ps

module dispatch #(
    parameter int S_REGS = 32,
    parameter int M_REGS = 16
) (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            req,
    input  dispatch_pkg::instr_u            instr,
    input  logic                            freeze,
    input  logic                            flush,
    input  logic                            branch_resolved,
    input  logic                            wb_s_en,
    input  logic [$clog2(S_REGS)-1:0]       wb_s_rd,
    input  logic                            wb_m_en,
    input  logic [$clog2(M_REGS)-1:0]       wb_m_rd,
    input  logic [dispatch_pkg::NUM_FU-1:0] fu_busy,
    output logic                            ack,
    output logic                            issue_en,
    output logic [2:0]                      issue_idx,
    output logic                            out_valid,
    output logic [2:0]                      out_fu_idx,
    output logic [4:0]                      out_rd,
    output logic [4:0]                      out_rs1,
    output logic [4:0]                      out_rs2,
    output logic [4:0]                      out_rs3,
    output logic [1:0]                      out_t1,
    output logic [1:0]                      out_t2,
    output logic [1:0]                      out_t3,
    output logic [31:0]                     out_imm,
    output dispatch_pkg::alu_op_e           out_alu_op,
    output logic                            out_spec
);

    localparam int SW = $clog2(S_REGS);
    localparam int MW = $clog2(M_REGS);

    dispatch_pkg::fu_type_e fu_type;
    dispatch_pkg::alu_op_e  alu_op;
    logic [2:0]             fu_idx;
    logic                   s_reg_write;
    logic                   m_reg_write;
    logic [31:0]            imm;
    logic                   is_branch;

    logic [SW-1:0]          s_rd;
    logic [SW-1:0]          s_rs1;
    logic [SW-1:0]          s_rs2;
    logic [MW-1:0]          m_rd;
    logic [MW-1:0]          m_rs1;
    logic [MW-1:0]          m_rs2;
    logic [MW-1:0]          m_rs3;
    logic [S_REGS-1:0]      s_busy;
    logic [2*S_REGS-1:0]    s_tag;
    logic [M_REGS-1:0]      m_busy;
    logic [2*M_REGS-1:0]    m_tag;

    logic                   unit_busy;
    logic                   waw;
    logic                   hazard;
    logic                   accept;
    logic                   spec;
    logic [4:0]             n_rd;
    logic [4:0]             n_rs1;
    logic [4:0]             n_rs2;
    logic [4:0]             n_rs3;
    logic [1:0]             n_t1;
    logic [1:0]             n_t2;
    logic [1:0]             n_t3;

    control_unit u_cu (
        .instr       (instr),
        .fu_type     (fu_type),
        .fu_idx      (fu_idx),
        .s_reg_write (s_reg_write),
        .m_reg_write (m_reg_write),
        .imm         (imm),
        .alu_op      (alu_op),
        .is_branch   (is_branch)
    );

    // same word, scalar and matrix register views
    assign s_rd  = instr.s.rd[SW-1:0];
    assign s_rs1 = instr.s.rs1[SW-1:0];
    assign s_rs2 = instr.s.rs2[SW-1:0];
    assign m_rd  = instr.m.rd[MW-1:0];
    assign m_rs1 = instr.m.rs1[MW-1:0];
    assign m_rs2 = instr.m.rs2[MW-1:0];
    assign m_rs3 = instr.m.rs3[MW-1:0];

    // unknown opcodes need no unit and are simply acknowledged
    assign unit_busy = (fu_type != dispatch_pkg::FU_NONE) && fu_busy[fu_idx];
    assign waw       = (s_reg_write && s_busy[s_rd]) || (m_reg_write && m_busy[m_rd]);
    assign hazard    = unit_busy || waw;
    assign accept    = req && !ack && !hazard && !freeze && !flush;
    assign issue_en  = accept && (fu_type != dispatch_pkg::FU_NONE);
    assign issue_idx = fu_idx;

    reg_status_table #(.NREGS(S_REGS)) u_rst_s (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (accept && s_reg_write),
        .di_sel   (s_rd),
        .di_tag   ((fu_idx == dispatch_pkg::FU_LDST) ? dispatch_pkg::TAG_LOAD
                                                     : dispatch_pkg::TAG_EXEC),
        .wb_write (wb_s_en),
        .wb_sel   (wb_s_rd),
        .busy     (s_busy),
        .tag      (s_tag)
    );

    reg_status_table #(.NREGS(M_REGS)) u_rst_m (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (accept && m_reg_write),
        .di_sel   (m_rd),
        .di_tag   ((fu_idx == dispatch_pkg::FU_MLDST) ? dispatch_pkg::TAG_LOAD
                                                      : dispatch_pkg::TAG_EXEC),
        .wb_write (wb_m_en),
        .wb_sel   (wb_m_rd),
        .busy     (m_busy),
        .tag      (m_tag)
    );

    // operand fields and producer tags per unit class
    always_comb begin
        n_rd  = 5'(instr.s.rd);
        n_rs1 = 5'(instr.s.rs1);
        n_rs2 = 5'(instr.s.rs2);
        n_rs3 = '0;
        n_t1  = s_tag[2*s_rs1 +: 2];
        n_t2  = s_tag[2*s_rs2 +: 2];
        n_t3  = dispatch_pkg::TAG_READY;
        case (fu_type)
            dispatch_pkg::FU_M: begin
                // matrix destination, scalar base and offset registers
                n_rd = 5'(instr.m.rd);
            end
            dispatch_pkg::FU_G: begin
                n_rd  = 5'(instr.m.rd);
                n_rs1 = 5'(instr.m.rs1);
                n_rs2 = 5'(instr.m.rs2);
                n_rs3 = 5'(instr.m.rs3);
                n_t1  = m_tag[2*m_rs1 +: 2];
                n_t2  = m_tag[2*m_rs2 +: 2];
                n_t3  = m_tag[2*m_rs3 +: 2];
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack       <= 1'b0;
            out_valid <= 1'b0;
            spec      <= 1'b0;
        end else begin
            out_valid <= issue_en;
            // four-phase: hold ack until fetch drops req
            if (accept) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end
            if (branch_resolved || flush) begin
                spec <= 1'b0;
            end else if (accept && is_branch) begin
                spec <= 1'b1;
            end
        end
    end

    // bundle payload, qualified by out_valid
    always_ff @(posedge CLK) begin
        if (issue_en) begin
            out_fu_idx <= fu_idx;
            out_rd     <= n_rd;
            out_rs1    <= n_rs1;
            out_rs2    <= n_rs2;
            out_rs3    <= n_rs3;
            out_t1     <= n_t1;
            out_t2     <= n_t2;
            out_t3     <= n_t3;
            out_imm    <= imm;
            out_alu_op <= alu_op;
            out_spec   <= spec;
        end
    end

    a_ack_no_hazard: assert property (
        @(posedge CLK) disable iff (!nRST)
        $rose(ack) |-> $past(!hazard)
    ) else $error("dispatch: ack raised on an instruction with a hazard");

endmodule

/* hdl/dispatch_pkg.sv */
package dispatch_pkg;

    // major opcodes
    localparam logic [6:0] OP_ALU_R   = 7'b0110011;
    localparam logic [6:0] OP_ALU_I   = 7'b0010011;
    localparam logic [6:0] OP_LOAD    = 7'b0000011;
    localparam logic [6:0] OP_STORE   = 7'b0100011;
    localparam logic [6:0] OP_BRANCH  = 7'b1100011;
    localparam logic [6:0] OP_M_LOAD  = 7'b0000111;
    localparam logic [6:0] OP_M_STORE = 7'b0100111;
    localparam logic [6:0] OP_GEMM    = 7'b1110111;

    // class of unit an instruction needs
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_S    = 2'd1,
        FU_M    = 2'd2,
        FU_G    = 2'd3
    } fu_type_e;

    // positions in the unit busy vector
    localparam logic [2:0] FU_ALU    = 3'd0;
    localparam logic [2:0] FU_LDST   = 3'd1;
    localparam logic [2:0] FU_BRANCH = 3'd2;
    localparam logic [2:0] FU_MLDST  = 3'd3;
    localparam logic [2:0] FU_GEMM   = 3'd4;
    localparam int         NUM_FU    = 5;

    // producer tags, 0 means the value is already in the register file
    localparam logic [1:0] TAG_READY = 2'd0;
    localparam logic [1:0] TAG_EXEC  = 2'd1;
    localparam logic [1:0] TAG_LOAD  = 2'd2;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } s_fields_t;

    // matrix registers are 4 bits wide and packed at the top of the word
    typedef struct packed {
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
        logic [3:0] rs3;
        logic [8:0] mfunct;
        logic [6:0] opcode;
    } m_fields_t;

    typedef union packed {
        s_fields_t s;
        m_fields_t m;
    } instr_u;

endpackage

/* hdl/dispatch_top.sv */
`timescale 1ns/1ps

module dispatch_top #(
    parameter int S_REGS = 32,
    parameter int M_REGS = 16
) (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            req,
    input  dispatch_pkg::instr_u            instr,
    input  logic                            freeze,
    input  logic                            flush,
    input  logic                            branch_resolved,
    input  logic                            wb_s_en,
    input  logic [$clog2(S_REGS)-1:0]       wb_s_rd,
    input  logic                            wb_m_en,
    input  logic [$clog2(M_REGS)-1:0]       wb_m_rd,
    input  logic [dispatch_pkg::NUM_FU-1:0] fu_done,
    output logic                            ack,
    output logic                            out_valid,
    output logic [2:0]                      out_fu_idx,
    output logic [4:0]                      out_rd,
    output logic [4:0]                      out_rs1,
    output logic [4:0]                      out_rs2,
    output logic [4:0]                      out_rs3,
    output logic [1:0]                      out_t1,
    output logic [1:0]                      out_t2,
    output logic [1:0]                      out_t3,
    output logic [31:0]                     out_imm,
    output dispatch_pkg::alu_op_e           out_alu_op,
    output logic                            out_spec
);

    logic                            issue_en;
    logic [2:0]                      issue_idx;
    logic [dispatch_pkg::NUM_FU-1:0] fu_busy;

    dispatch #(
        .S_REGS (S_REGS),
        .M_REGS (M_REGS)
    ) u_dispatch (
        .CLK             (CLK),
        .nRST            (nRST),
        .req             (req),
        .instr           (instr),
        .freeze          (freeze),
        .flush           (flush),
        .branch_resolved (branch_resolved),
        .wb_s_en         (wb_s_en),
        .wb_s_rd         (wb_s_rd),
        .wb_m_en         (wb_m_en),
        .wb_m_rd         (wb_m_rd),
        .fu_busy         (fu_busy),
        .ack             (ack),
        .issue_en        (issue_en),
        .issue_idx       (issue_idx),
        .out_valid       (out_valid),
        .out_fu_idx      (out_fu_idx),
        .out_rd          (out_rd),
        .out_rs1         (out_rs1),
        .out_rs2         (out_rs2),
        .out_rs3         (out_rs3),
        .out_t1          (out_t1),
        .out_t2          (out_t2),
        .out_t3          (out_t3),
        .out_imm         (out_imm),
        .out_alu_op      (out_alu_op),
        .out_spec        (out_spec)
    );

    // unit reservations, set on issue and released by done pulses
    fu_status u_fu_status (
        .CLK       (CLK),
        .nRST      (nRST),
        .issue_en  (issue_en),
        .issue_idx (issue_idx),
        .fu_done   (fu_done),
        .busy      (fu_busy)
    );

endmodule

/* hdl/fu_status.sv */
`timescale 1ns/1ps

module fu_status (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            issue_en,
    input  logic [2:0]                      issue_idx,
    input  logic [dispatch_pkg::NUM_FU-1:0] fu_done,
    output logic [dispatch_pkg::NUM_FU-1:0] busy
);

    logic [dispatch_pkg::NUM_FU-1:0] issue_mask;

    always_comb begin
        issue_mask = '0;
        if (issue_en) begin
            issue_mask[issue_idx] = 1'b1;
        end
    end

    // done pulses release the unit, an issue reserves it again
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~fu_done) | issue_mask;
        end
    end

    // an execute unit may only finish work that was issued to it
    a_done_on_busy: assert property (
        @(posedge CLK) disable iff (!nRST)
        (fu_done & ~busy) == '0
    ) else $error("fu_status: done pulse for idle unit, done=%b busy=%b", fu_done, busy);

endmodule

/* hdl/reg_status_table.sv */
`timescale 1ns/1ps

module reg_status_table #(
    parameter int NREGS = 32
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     di_write,
    input  logic [$clog2(NREGS)-1:0] di_sel,
    input  logic [1:0]               di_tag,
    input  logic                     wb_write,
    input  logic [$clog2(NREGS)-1:0] wb_sel,
    output logic [NREGS-1:0]         busy,
    output logic [2*NREGS-1:0]       tag
);

    // tag 0 doubles as "ready", so the tags are cleared together with busy
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            tag  <= '0;
        end else begin
            if (wb_write) begin
                busy[wb_sel]        <= 1'b0;
                tag[2*wb_sel +: 2]  <= dispatch_pkg::TAG_READY;
            end
            // a new producer overrides a writeback to the same entry
            if (di_write) begin
                busy[di_sel]        <= 1'b1;
                tag[2*di_sel +: 2]  <= di_tag;
            end
        end
    end

    // the WAW check in dispatch must keep a second producer out
    a_no_double_reserve: assert property (
        @(posedge CLK) disable iff (!nRST)
        di_write |-> !busy[di_sel]
    ) else $error("reg_status_table: dispatch write to busy entry %0d", di_sel);

endmodule

/* verif/dispatch_input.txt */
# name kind value(hex) acc(y n -) fu_idx rd t1 t2 t3 spec
# kinds I instr, W writeback (bit 8 marks matrix), D done mask, F flush with instr, B resolve
alu_add      I 002082B3 y 0 5  0 0 0 0
done_alu     D 00000001 - 0 0  0 0 0 0
load_x6      I 0082A303 y 1 6  1 0 0 0
done_ldst    D 00000002 - 0 0  0 0 0 0
alu_dep      I 005303B3 y 0 7  2 1 0 0
wb_x5        W 00000005 - 0 0  0 0 0 0
done_alu2    D 00000001 - 0 0  0 0 0 0
alu_ready    I 00628433 y 0 8  0 2 0 0
done_alu3    D 00000001 - 0 0  0 0 0 0
waw_stall    I 00100393 n 0 0  0 0 0 0
wb_x7        W 00000007 y 0 7  0 0 0 0
struct_stall I 402084B3 n 0 0  0 0 0 0
done_alu4    D 00000001 y 0 9  0 0 0 0
store        I 00832223 y 1 4  2 1 0 0
branch       I 00208863 y 2 16 0 0 0 0
mload_spec   I 30038007 y 3 3  1 0 0 1
gemm_spec    I 43120077 y 4 4  2 0 0 1
resolve      B 00000000 - 0 0  0 0 0 0
done_mldst   D 00000008 - 0 0  0 0 0 0
mload_waw    I 40000007 n 0 0  0 0 0 0
wb_m4        W 00000104 y 3 4  0 0 0 0
done_br      D 00000004 - 0 0  0 0 0 0
branch2      I 00208863 y 2 16 0 0 0 0
done_alu5    D 00000001 - 0 0  0 0 0 0
flush_alu    F FFF48513 y 0 10 1 0 0 0
nop_unknown  I 0000007F y 7 0  0 0 0 0

/* verif/dispatch_tb.sv */
`timescale 1ns/1ps

module dispatch_tb;

    logic                  CLK;
    logic                  nRST;
    logic                  req;
    dispatch_pkg::instr_u  instr;
    logic                  freeze;
    logic                  flush;
    logic                  branch_resolved;
    logic                  wb_s_en;
    logic [4:0]            wb_s_rd;
    logic                  wb_m_en;
    logic [3:0]            wb_m_rd;
    logic [4:0]            fu_done;
    logic                  ack;
    logic                  out_valid;
    logic [2:0]            out_fu_idx;
    logic [4:0]            out_rd;
    logic [4:0]            out_rs1;
    logic [4:0]            out_rs2;
    logic [4:0]            out_rs3;
    logic [1:0]            out_t1;
    logic [1:0]            out_t2;
    logic [1:0]            out_t3;
    logic [31:0]           out_imm;
    dispatch_pkg::alu_op_e out_alu_op;
    logic                  out_spec;

    // one entry per record of the input file
    string       rec_name[$];
    string       rec_kind[$];
    string       rec_acc[$];
    logic [31:0] rec_val[$];
    int          rec_fu[$];
    int          rec_rd[$];
    int          rec_t1[$];
    int          rec_t2[$];
    int          rec_t3[$];
    int          rec_spec[$];

    int          n_rec = 0;
    bit          loaded = 0;
    int          errors = 0;
    int          failed = 0;
    bit          test_bad;
    bit          pending;
    logic [31:0] pend_word;
    string       cur_name;
    logic [15:0] lfsr;

    dispatch_top DUT (
        .CLK             (CLK),
        .nRST            (nRST),
        .req             (req),
        .instr           (instr),
        .freeze          (freeze),
        .flush           (flush),
        .branch_resolved (branch_resolved),
        .wb_s_en         (wb_s_en),
        .wb_s_rd         (wb_s_rd),
        .wb_m_en         (wb_m_en),
        .wb_m_rd         (wb_m_rd),
        .fu_done         (fu_done),
        .ack             (ack),
        .out_valid       (out_valid),
        .out_fu_idx      (out_fu_idx),
        .out_rd          (out_rd),
        .out_rs1         (out_rs1),
        .out_rs2         (out_rs2),
        .out_rs3         (out_rs3),
        .out_t1          (out_t1),
        .out_t2          (out_t2),
        .out_t3          (out_t3),
        .out_imm         (out_imm),
        .out_alu_op      (out_alu_op),
        .out_spec        (out_spec)
    );

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic load_records(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       name;
        string       kind;
        string       acc;
        logic [31:0] val;
        int          fu;
        int          rd;
        int          t1;
        int          t2;
        int          t3;
        int          sp;
        ok = 1'b0;
        fd = $fopen("verif/dispatch_input.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                if (line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %s %d %d %d %d %d %d",
                                name, kind, val, acc, fu, rd, t1, t2, t3, sp);
                    if (n == 10) begin
                        rec_name.push_back(name);
                        rec_kind.push_back(kind);
                        rec_val.push_back(val);
                        rec_acc.push_back(acc);
                        rec_fu.push_back(fu);
                        rec_rd.push_back(rd);
                        rec_t1.push_back(t1);
                        rec_t2.push_back(t2);
                        rec_t3.push_back(t3);
                        rec_spec.push_back(sp);
                    end
                end
            end
            $fclose(fd);
            n_rec = rec_name.size();
            ok = (n_rec > 0);
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", cur_name, msg);
        errors++;
        test_bad = 1'b1;
    endtask

    task automatic check_field(input string field, input int expv, input int actv);
        assert (expv == actv) else begin
            $display("ERROR %s %s expected %0d actual %0d", cur_name, field, expv, actv);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    // I, S and B immediates of the scalar encodings, sign-extended
    task automatic expected_imm(input logic [31:0] x, output bit has, output int v);
        has = 1'b1;
        v   = 0;
        case (x[6:0])
            dispatch_pkg::OP_ALU_I, dispatch_pkg::OP_LOAD, dispatch_pkg::OP_M_LOAD: begin
                v = $signed(x[31:20]);
            end
            dispatch_pkg::OP_STORE, dispatch_pkg::OP_M_STORE: begin
                v = $signed({x[31:25], x[11:7]});
            end
            dispatch_pkg::OP_BRANCH: begin
                v = $signed({x[31], x[7], x[30:25], x[11:8], 1'b0});
            end
            default: begin
                has = 1'b0;
            end
        endcase
    endtask

    // RV32I arithmetic selected by funct3, funct7 0x20 picks sub and sra
    function automatic dispatch_pkg::alu_op_e expected_alu_op(input dispatch_pkg::instr_u w);
        dispatch_pkg::alu_op_e op;
        case (w.s.funct3)
            3'd0: begin
                if (w.s.opcode == dispatch_pkg::OP_ALU_R && w.s.funct7 == 7'h20) begin
                    op = dispatch_pkg::ALU_SUB;
                end else begin
                    op = dispatch_pkg::ALU_ADD;
                end
            end
            3'd1: op = dispatch_pkg::ALU_SLL;
            3'd2: op = dispatch_pkg::ALU_SLT;
            3'd3: op = dispatch_pkg::ALU_SLTU;
            3'd4: op = dispatch_pkg::ALU_XOR;
            3'd5: op = (w.s.funct7 == 7'h20) ? dispatch_pkg::ALU_SRA : dispatch_pkg::ALU_SRL;
            3'd6: op = dispatch_pkg::ALU_OR;
            default: op = dispatch_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // one write-back, done or resolve pulse of a single cycle
    task automatic pulse_inputs(input string kind, input logic [31:0] val);
        @(posedge CLK);
        if (kind == "W" && val[8]) begin
            wb_m_en <= 1'b1;
            wb_m_rd <= val[3:0];
        end else if (kind == "W") begin
            wb_s_en <= 1'b1;
            wb_s_rd <= val[4:0];
        end else if (kind == "D") begin
            fu_done <= val[4:0];
        end else if (kind == "B") begin
            branch_resolved <= 1'b1;
        end
        @(posedge CLK);
        wb_s_en         <= 1'b0;
        wb_m_en         <= 1'b0;
        fu_done         <= '0;
        branch_resolved <= 1'b0;
    endtask

    task automatic wait_ack(output bit got);
        int n;
        got = 1'b0;
        n   = 0;
        while (!got && n < 16) begin
            @(negedge CLK);
            got = ack;
            n++;
        end
    endtask

    // second half of the four-phase handshake
    task automatic release_req();
        @(posedge CLK);
        req <= 1'b0;
        @(negedge CLK);
        assert (!out_valid) else report_problem("out_valid held for more than one cycle");
        while (ack) begin
            @(negedge CLK);
        end
    endtask

    task automatic check_bundle(input int i);
        dispatch_pkg::instr_u w;
        bit                   has_imm;
        int                   exp_imm;
        w = pend_word;
        if (rec_fu[i] == 7) begin
            assert (!out_valid) else report_problem("bundle issued for an opcode with no unit");
        end else begin
            assert (out_valid) else report_problem("out_valid low when ack rose");
            check_field("fu_idx", rec_fu[i], out_fu_idx);
            check_field("rd", rec_rd[i], out_rd);
            check_field("t1", rec_t1[i], out_t1);
            check_field("t2", rec_t2[i], out_t2);
            check_field("t3", rec_t3[i], out_t3);
            check_field("spec", rec_spec[i], out_spec);
            // GEMM names matrix sources, every other class scalar ones
            if (rec_fu[i] == dispatch_pkg::FU_GEMM) begin
                check_field("rs1", w.m.rs1, out_rs1);
                check_field("rs2", w.m.rs2, out_rs2);
                check_field("rs3", w.m.rs3, out_rs3);
            end else begin
                check_field("rs1", w.s.rs1, out_rs1);
                check_field("rs2", w.s.rs2, out_rs2);
            end
            expected_imm(pend_word, has_imm, exp_imm);
            if (has_imm) begin
                check_field("imm", exp_imm, out_imm);
            end
            if (rec_fu[i] == dispatch_pkg::FU_ALU) begin
                check_field("alu_op", expected_alu_op(w), out_alu_op);
            end
        end
    endtask

    task automatic run_record(input int i);
        bit    got;
        int    gap;
        string kind;
        cur_name = rec_name[i];
        kind     = rec_kind[i];
        test_bad = 1'b0;
        if (kind == "I" || kind == "F") begin
            @(posedge CLK);
            req       <= 1'b1;
            instr     <= rec_val[i];
            pending   = 1'b1;
            pend_word = rec_val[i];
            if (kind == "F") begin
                flush <= 1'b1;
                @(posedge CLK);
                flush <= 1'b0;
                @(negedge CLK);
                assert (!ack) else report_problem("instruction accepted during flush");
            end
        end else begin
            pulse_inputs(kind, rec_val[i]);
        end
        if (rec_acc[i] == "y") begin
            assert (pending) else report_problem("ack expected but no instruction is pending");
            if (pending) begin
                wait_ack(got);
                assert (got) else report_problem("no ack within 16 cycles");
                if (got) begin
                    check_bundle(i);
                end
                release_req();
                pending = 1'b0;
            end
        end else if (rec_acc[i] == "n") begin
            wait_ack(got);
            assert (!got) else report_problem("unexpected ack for a stalled instruction");
            if (got) begin
                release_req();
                pending = 1'b0;
            end
        end
        if (test_bad) begin
            failed++;
        end
        $display("%-14s %s", cur_name, test_bad ? "FAIL" : "ok");
        // idle gap of 0 to 3 cycles
        lfsr = lfsr_next(lfsr);
        gap  = lfsr[0];
        lfsr = lfsr_next(lfsr);
        gap  = gap + 2 * lfsr[0];
        repeat (gap) @(posedge CLK);
    endtask

    initial begin
        bit ok;
        nRST            = 1'b0;
        req             = 1'b0;
        instr           = '0;
        freeze          = 1'b0;
        flush           = 1'b0;
        branch_resolved = 1'b0;
        wb_s_en         = 1'b0;
        wb_s_rd         = '0;
        wb_m_en         = 1'b0;
        wb_m_rd         = '0;
        fu_done         = '0;
        pending         = 1'b0;
        pend_word       = '0;
        lfsr            = 16'd29266;
        load_records(ok);
        if (!ok) begin
            $display("could not read any record from verif/dispatch_input.txt");
            $display("Errors found");
            $finish;
        end else begin
            repeat (8) @(posedge CLK);
            nRST   <= 1'b1;
            loaded = 1'b1;
            @(posedge CLK);
            for (int i = 0; i < n_rec; i++) begin
                run_record(i);
            end
            $display("%0d tests, %0d failed, %0d errors", n_rec, failed, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    // budget of 40 cycles per record
    initial begin
        wait (loaded);
        repeat (40 * n_rec) @(posedge CLK);
        $display("timeout, tests did not finish within %0d cycles", 40 * n_rec);
        $display("Errors found");
        $finish;
    end

endmodule
